// File: verilog/mem_resp_pkg.sv
`default_nettype none

package mem_resp_pkg;

	// ==================================================
	// Sizes
	// ==================================================

	// Hardware threads sharing the memory return path
	localparam int NTHREADS = 4;

	// Architectural registers per thread
	localparam int NREGS = 64;

	// Width of one load response
	localparam int DATA_W = 64;

	// Number of queued responses between capture and writeback
	localparam int FIFO_DEPTH = 16;

	// Width of the saturating overflow drop counter
	localparam int DROP_W = 8;

	// ==================================================
	// Vector types
	// ==================================================

	// Hardware thread number
	typedef logic [$clog2(NTHREADS)-1:0] thread_t;

	// One bit per thread, used by the rollback mask
	typedef logic [NTHREADS-1:0] thread_mask_t;

	// Destination register number inside one thread
	typedef logic [$clog2(NREGS)-1:0] reg_idx_t;

	// Load data returned by memory
	typedef logic [DATA_W-1:0] data_t;

	// One pending bit per register of a single thread
	typedef logic [NREGS-1:0] reg_bitmap_t;

	// Pending rows of all threads, indexed by thread number
	typedef reg_bitmap_t [NTHREADS-1:0] pending_t;

	// Queue occupancy, needs to reach FIFO_DEPTH itself
	typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt_t;

	// Count of responses lost to a full queue
	typedef logic [DROP_W-1:0] drop_cnt_t;

	// ==================================================
	// Response record
	// ==================================================

	// The v bit is meaningful only once the entry sits in the queue.
	// A rollback clears it in place so the drain stage can skip the entry
	typedef struct packed {
		logic     v;
		thread_t  thread;
		reg_idx_t tgt;
		data_t    data;
	} mem_resp_t;

endpackage

`default_nettype wire

// File: verilog/resp_capture.sv
`timescale 1ns/1ps
`default_nettype none

module resp_capture (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          mem_valid,
	input  wire mem_resp_pkg::mem_resp_t mem_resp,
	input  wire mem_resp_pkg::thread_mask_t rollback,
	input  wire                          full,
	output logic                         push,
	output mem_resp_pkg::mem_resp_t      push_resp,
	output logic                         overflow,
	output mem_resp_pkg::drop_cnt_t      drop_count
);

	// ==================================================
	// Staging register
	// ==================================================

	// Staged response is present and passed the arrival screen
	logic stage_valid;
	// Payload of the staged response
	mem_resp_pkg::mem_resp_t stage_resp;
	// Staged response also passes the rollback screen in the push cycle
	logic stage_live;

	// Memory cannot be stalled, so a new strobe simply replaces the stage.
	// A thread that is being rolled back while its data arrives is screened here
	always_ff @(posedge clk) begin
		if (rst) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= mem_valid && !rollback[mem_resp.thread];
		end
	end

	// Payload only moves when something arrives
	always_ff @(posedge clk) begin
		if (mem_valid) begin
			stage_resp <= mem_resp;
		end
	end

	// The second screen catches a rollback that lands one cycle after arrival
	assign stage_live = stage_valid && !rollback[stage_resp.thread];

	// ==================================================
	// Push into the queue
	// ==================================================

	// The queue trusts this stage to never push while full
	assign push = stage_live && !full;

	// The incoming v field is ignored; every pushed entry starts out valid
	always_comb begin
		push_resp = stage_resp;
		push_resp.v = 1'b1;
	end

	// Overflow bookkeeping.
	// Only a live response lost to a full queue counts and rollback drops are silent
	always_ff @(posedge clk) begin
		if (rst) begin
			overflow <= 1'b0;
			drop_count <= '0;
		end else if (stage_live && full) begin
			overflow <= 1'b1;
			// Counter holds at its maximum
			if (drop_count != '1) begin
				drop_count <= drop_count + 1'b1;
			end
		end
	end

	// A rolled-back thread must never reach the queue
	a_no_push_rolled_back: assert property (@(posedge clk) disable iff (rst)
		push |-> !rollback[push_resp.thread]);

endmodule

`default_nettype wire

// File: verilog/mem_resp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module mem_resp_fifo (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          push,
	input  wire mem_resp_pkg::mem_resp_t push_resp,
	input  wire                          pop,
	input  wire mem_resp_pkg::thread_mask_t rollback,
	output mem_resp_pkg::mem_resp_t      head,
	output mem_resp_pkg::fifo_cnt_t      count,
	output logic                         empty,
	output logic                         full,
	output mem_resp_pkg::pending_t       pending
);

	// ==================================================
	// Storage and pointers
	// ==================================================

	// Response storage, small enough to live in distributed memory
	mem_resp_pkg::mem_resp_t mem [mem_resp_pkg::FIFO_DEPTH];

	// Depth is a power of two so the pointers wrap on their own
	logic [$clog2(mem_resp_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(mem_resp_pkg::FIFO_DEPTH)-1:0] rd_ptr;

	// Storage update.
	// Every stored entry is screened against the rollback mask each cycle,
	// whether or not it is still between the pointers
	always_ff @(posedge clk) begin
		for (int i = 0; i < mem_resp_pkg::FIFO_DEPTH; i++) begin
			if (rollback[mem[i].thread]) begin
				mem[i].v <= 1'b0;
			end
		end
		// The new entry overrides the loop above for its own slot
		if (push) begin
			mem[wr_ptr] <= push_resp;
			mem[wr_ptr].v <= push_resp.v && !rollback[push_resp.thread];
		end
	end

	// Pointers advance independently so push and pop can share a cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// First-word fall-through view of the oldest entry
	assign head = mem[rd_ptr];

	// ==================================================
	// Occupancy
	// ==================================================

	// The separate count tells a full queue from an empty one
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign empty = (count == '0);
	assign full = (count == mem_resp_pkg::FIFO_DEPTH);

	// ==================================================
	// Pending register bitmaps
	// ==================================================

	// Later assignments win, so the order below encodes the priority:
	// pop clears, a push of the same register sets it again,
	// and a rollback zeroes the whole row over both
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
		end else begin
			if (pop) begin
				pending[head.thread][head.tgt] <= 1'b0;
			end
			if (push) begin
				pending[push_resp.thread][push_resp.tgt] <= 1'b1;
			end
			for (int t = 0; t < mem_resp_pkg::NTHREADS; t++) begin
				if (rollback[t]) begin
					pending[t] <= '0;
				end
			end
		end
	end

	// The capture stage owns the full check
	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		push |-> !full);

	// The drain stage only pops a non-empty queue
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		pop |-> !empty);

	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		count <= mem_resp_pkg::FIFO_DEPTH);

endmodule

`default_nettype wire

// File: verilog/resp_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module resp_writeback (
	input  wire                          clk,
	input  wire                          rst,
	input  wire mem_resp_pkg::mem_resp_t head,
	input  wire                          empty,
	input  wire                          wb_hold,
	input  wire mem_resp_pkg::thread_mask_t rollback,
	output logic                         pop,
	output logic                         wb_valid,
	output mem_resp_pkg::thread_t        wb_thread,
	output mem_resp_pkg::reg_idx_t       wb_tgt,
	output mem_resp_pkg::data_t          wb_data
);

	// ==================================================
	// Drain control
	// ==================================================

	// Head entry is popped and turns into a register write
	logic keep;

	// One entry per cycle unless the register-file port is taken.
	// Invalidated entries are popped too but produce no write
	assign pop = !empty && !wb_hold;

	// The queue clears v one edge after a rollback, so a rollback in this
	// very cycle is checked here directly
	assign keep = pop && head.v && !rollback[head.thread];

	// ==================================================
	// Writeback register
	// ==================================================

	// Strobe is high for one cycle per surviving entry
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= keep;
		end
	end

	// Fields are only meaningful alongside wb_valid
	always_ff @(posedge clk) begin
		if (keep) begin
			wb_thread <= head.thread;
			wb_tgt <= head.tgt;
			wb_data <= head.data;
		end
	end

	// An entry invalidated in the queue must never write the register file
	a_no_wb_invalid: assert property (@(posedge clk) disable iff (rst)
		(pop && !head.v) |=> !wb_valid);

endmodule

`default_nettype wire

// File: verilog/mem_resp_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_resp_top (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          mem_valid,
	input  wire mem_resp_pkg::mem_resp_t mem_resp,
	input  wire mem_resp_pkg::thread_mask_t rollback,
	input  wire                          wb_hold,
	output logic                         wb_valid,
	output mem_resp_pkg::thread_t        wb_thread,
	output mem_resp_pkg::reg_idx_t       wb_tgt,
	output mem_resp_pkg::data_t          wb_data,
	output mem_resp_pkg::fifo_cnt_t      count,
	output mem_resp_pkg::pending_t       pending,
	output logic                         full,
	output logic                         overflow,
	output mem_resp_pkg::drop_cnt_t      drop_count
);

	// ==================================================
	// Stage links
	// ==================================================

	// Capture to queue
	logic push;
	mem_resp_pkg::mem_resp_t push_resp;

	// Queue to writeback
	mem_resp_pkg::mem_resp_t head;
	logic empty;
	logic pop;

	// Input side, one cycle of staging
	resp_capture u_capture (
		.clk(clk),
		.rst(rst),
		.mem_valid(mem_valid),
		.mem_resp(mem_resp),
		.rollback(rollback),
		.full(full),
		.push(push),
		.push_resp(push_resp),
		.overflow(overflow),
		.drop_count(drop_count)
	);

	// Queue with rollback invalidation and pending bitmaps
	mem_resp_fifo u_fifo (
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_resp(push_resp),
		.pop(pop),
		.rollback(rollback),
		.head(head),
		.count(count),
		.empty(empty),
		.full(full),
		.pending(pending)
	);

	// Output side, register file writes
	resp_writeback u_writeback (
		.clk(clk),
		.rst(rst),
		.head(head),
		.empty(empty),
		.wb_hold(wb_hold),
		.rollback(rollback),
		.pop(pop),
		.wb_valid(wb_valid),
		.wb_thread(wb_thread),
		.wb_tgt(wb_tgt),
		.wb_data(wb_data)
	);

endmodule

`default_nettype wire

// File: dv/mem_resp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_resp_tb;

	// ==================================================
	// Test lengths and run limit
	// ==================================================

	localparam int RESET_CYCLES = 4;
	localparam int SINGLE_LEN = 20;
	localparam int RANDOM_LEN = 300;
	localparam int ROLLBACK_LEN = 300;
	localparam int DUP_LEN = 200;
	localparam int SAME_REG_LEN = 20;
	localparam int BURST_LEN = 24;
	localparam int DRAIN_LIMIT = 200;
	localparam int MARGIN = 1000;
	// Five tests are each closed by one drain
	localparam int CYCLE_LIMIT = RESET_CYCLES + SINGLE_LEN + RANDOM_LEN + ROLLBACK_LEN
		+ DUP_LEN + BURST_LEN + 5 * DRAIN_LIMIT + MARGIN;
	// With an empty queue and the port held, only FIFO_DEPTH responses fit
	localparam int BURST_KEPT = (BURST_LEN < mem_resp_pkg::FIFO_DEPTH) ?
		BURST_LEN : mem_resp_pkg::FIFO_DEPTH;

	logic clk;
	logic rst;
	logic mem_valid;
	mem_resp_pkg::mem_resp_t mem_resp;
	mem_resp_pkg::thread_mask_t rollback;
	logic wb_hold;
	logic wb_valid;
	mem_resp_pkg::thread_t wb_thread;
	mem_resp_pkg::reg_idx_t wb_tgt;
	mem_resp_pkg::data_t wb_data;
	mem_resp_pkg::fifo_cnt_t count;
	mem_resp_pkg::pending_t pending;
	logic full;
	logic overflow;
	mem_resp_pkg::drop_cnt_t drop_count;

	mem_resp_top DUT (
		.clk(clk),
		.rst(rst),
		.mem_valid(mem_valid),
		.mem_resp(mem_resp),
		.rollback(rollback),
		.wb_hold(wb_hold),
		.wb_valid(wb_valid),
		.wb_thread(wb_thread),
		.wb_tgt(wb_tgt),
		.wb_data(wb_data),
		.count(count),
		.pending(pending),
		.full(full),
		.overflow(overflow),
		.drop_count(drop_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==================================================
	// Bookkeeping and random numbers
	// ==================================================

	int errors;
	int test_errors_base;
	int tests_passed;
	int tests_failed;
	string test_name;
	logic [31:0] lcg_state;

	// Only the upper half is returned because the low bits of an LCG repeat quickly
	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	function automatic logic chance(input int unsigned pct);
		return (32'(next_rand()) % 32'd100) < pct;
	endfunction

	// The v field is random because the capture stage must ignore it
	function automatic mem_resp_pkg::mem_resp_t rand_resp(input int unsigned n_thr,
		input int unsigned n_reg);
		mem_resp_pkg::mem_resp_t r;
		logic [15:0] bits;
		bits = next_rand();
		r.v = bits[0];
		r.thread = mem_resp_pkg::thread_t'(32'(next_rand()) % n_thr);
		r.tgt = mem_resp_pkg::reg_idx_t'(32'(next_rand()) % n_reg);
		r.data = {next_rand(), next_rand(), next_rand(), next_rand()};
		return r;
	endfunction

	task automatic report_mismatch(input string what, input logic [255:0] exp_val,
		input logic [255:0] act_val);
		$display("Error: %s %s expected %0h actual %0h", test_name, what, exp_val, act_val);
		errors++;
	endtask

	// ==================================================
	// Reference model
	// ==================================================

	// Queue front is the oldest response and staging mirrors the capture register
	mem_resp_pkg::mem_resp_t model_q[$];
	logic model_stg_valid;
	mem_resp_pkg::mem_resp_t model_stg;

	// Expected port values are updated on the same edge as the DUT
	logic exp_wb_valid;
	mem_resp_pkg::thread_t exp_wb_thread;
	mem_resp_pkg::reg_idx_t exp_wb_tgt;
	mem_resp_pkg::data_t exp_wb_data;
	mem_resp_pkg::fifo_cnt_t exp_count;
	logic exp_full;
	mem_resp_pkg::pending_t exp_pending;
	logic exp_overflow;
	mem_resp_pkg::drop_cnt_t exp_drop;

	always @(posedge clk) begin
		logic live;
		logic do_push;
		logic do_pop;
		mem_resp_pkg::mem_resp_t hd;
		mem_resp_pkg::mem_resp_t entry;
		mem_resp_pkg::pending_t pend;
		if (rst) begin
			model_q.delete();
			model_stg_valid = 1'b0;
			exp_wb_valid <= 1'b0;
			exp_count <= '0;
			exp_full <= 1'b0;
			exp_pending <= '0;
			exp_overflow <= 1'b0;
			exp_drop <= '0;
		end else begin
			// A staged response survives only if its thread is not rolled back now
			live = model_stg_valid && !rollback[model_stg.thread];
			do_push = live && (model_q.size() != mem_resp_pkg::FIFO_DEPTH);
			do_pop = (model_q.size() != 0) && !wb_hold;
			hd = '0;
			if (model_q.size() != 0) begin
				hd = model_q[0];
			end
			exp_wb_valid <= do_pop && hd.v && !rollback[hd.thread];
			if (do_pop && hd.v && !rollback[hd.thread]) begin
				exp_wb_thread <= hd.thread;
				exp_wb_tgt <= hd.tgt;
				exp_wb_data <= hd.data;
			end
			// A live response meeting a full queue is lost since memory cannot stall
			if (live && !do_push) begin
				exp_overflow <= 1'b1;
				if (exp_drop != '1) begin
					exp_drop <= exp_drop + 1'b1;
				end
			end
			// Pop clears and push sets, then rollback zeroes the row over both
			pend = exp_pending;
			if (do_pop) begin
				pend[hd.thread][hd.tgt] = 1'b0;
			end
			if (do_push) begin
				pend[model_stg.thread][model_stg.tgt] = 1'b1;
			end
			for (int t = 0; t < mem_resp_pkg::NTHREADS; t++) begin
				if (rollback[t]) begin
					pend[t] = '0;
				end
			end
			exp_pending <= pend;
			foreach (model_q[i]) begin
				if (rollback[model_q[i].thread]) begin
					model_q[i].v = 1'b0;
				end
			end
			if (do_pop) begin
				model_q.delete(0);
			end
			if (do_push) begin
				entry = model_stg;
				entry.v = 1'b1;
				model_q.push_back(entry);
			end
			exp_count <= mem_resp_pkg::fifo_cnt_t'(model_q.size());
			exp_full <= (model_q.size() == mem_resp_pkg::FIFO_DEPTH);
			model_stg_valid = mem_valid && !rollback[mem_resp.thread];
			if (mem_valid) begin
				model_stg = mem_resp;
			end
		end
	end

	// ==================================================
	// Checks against the model
	// ==================================================

	a_count: assert property (@(posedge clk) disable iff (rst) count == exp_count)
		else report_mismatch("count", $sampled(exp_count), $sampled(count));
	a_full: assert property (@(posedge clk) disable iff (rst) full == exp_full)
		else report_mismatch("full", $sampled(exp_full), $sampled(full));
	a_wb_valid: assert property (@(posedge clk) disable iff (rst) wb_valid == exp_wb_valid)
		else report_mismatch("wb_valid", $sampled(exp_wb_valid), $sampled(wb_valid));
	// Fields matter only with the strobe, and their order follows arrival order
	a_wb_fields: assert property (@(posedge clk) disable iff (rst) wb_valid |->
		{wb_thread, wb_tgt, wb_data} == {exp_wb_thread, exp_wb_tgt, exp_wb_data})
		else report_mismatch("writeback fields",
			$sampled({exp_wb_thread, exp_wb_tgt, exp_wb_data}),
			$sampled({wb_thread, wb_tgt, wb_data}));
	a_pending: assert property (@(posedge clk) disable iff (rst) pending == exp_pending)
		else report_mismatch("pending", $sampled(exp_pending), $sampled(pending));
	a_overflow: assert property (@(posedge clk) disable iff (rst) overflow == exp_overflow)
		else report_mismatch("overflow", $sampled(exp_overflow), $sampled(overflow));
	a_drop_count: assert property (@(posedge clk) disable iff (rst) drop_count == exp_drop)
		else report_mismatch("drop_count", $sampled(exp_drop), $sampled(drop_count));

	// ==================================================
	// Stimulus
	// ==================================================

	// Inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic idle_inputs();
		mem_valid = 1'b0;
		mem_resp = '0;
		rollback = '0;
		wb_hold = 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors_base = errors;
	endtask

	task automatic end_test();
		if (errors == test_errors_base) begin
			tests_passed++;
			$display("Test %s passed", test_name);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", test_name, errors - test_errors_base);
		end
	endtask

	// Releases all inputs and waits until the queue and the writeback strobe are idle
	task automatic drain(output int wb_seen);
		int waited;
		waited = 0;
		wb_seen = 0;
		idle_inputs();
		// Two edges let the staged response reach the queue
		repeat (2) begin
			step();
			wb_seen += int'(wb_valid);
		end
		while ((count != '0 || wb_valid) && waited < DRAIN_LIMIT) begin
			step();
			wb_seen += int'(wb_valid);
			waited++;
		end
		if (waited == DRAIN_LIMIT) begin
			$display("Test %s: queue did not drain within %0d cycles", test_name, DRAIN_LIMIT);
			errors++;
		end
	endtask

	initial begin
		int waited;
		int wb_seen;
		mem_resp_pkg::drop_cnt_t drop_base;
		lcg_state = 32'd12067;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		test_name = "reset";
		rst = 1'b1;
		idle_inputs();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// Reset values come first and then one response passes through an empty queue
		start_test("reset_single");
		repeat (2) step();
		mem_valid = 1'b1;
		mem_resp = rand_resp(mem_resp_pkg::NTHREADS, mem_resp_pkg::NREGS);
		step();
		mem_valid = 1'b0;
		waited = 0;
		while (!wb_valid && waited < SINGLE_LEN) begin
			step();
			waited++;
		end
		if (!wb_valid) begin
			$display("Test %s: no writeback seen for a single response", test_name);
			errors++;
		end
		drain(wb_seen);
		end_test();

		start_test("random_hold");
		for (int i = 0; i < RANDOM_LEN; i++) begin
			mem_valid = chance(50);
			mem_resp = rand_resp(mem_resp_pkg::NTHREADS, mem_resp_pkg::NREGS);
			wb_hold = chance(25);
			step();
		end
		drain(wb_seen);
		end_test();

		start_test("rollback");
		for (int i = 0; i < ROLLBACK_LEN; i++) begin
			mem_valid = chance(60);
			mem_resp = rand_resp(mem_resp_pkg::NTHREADS, mem_resp_pkg::NREGS);
			wb_hold = chance(30);
			rollback = chance(8) ? mem_resp_pkg::thread_mask_t'(next_rand()) : '0;
			step();
		end
		drain(wb_seen);
		end_test();

		// One register streamed back to back gives push and pop of it in one cycle,
		// then a small register set gives queued duplicates
		start_test("pending_dups");
		for (int i = 0; i < DUP_LEN; i++) begin
			mem_resp = rand_resp(2, 4);
			if (i < SAME_REG_LEN) begin
				mem_valid = 1'b1;
				mem_resp.thread = 2'd1;
				mem_resp.tgt = 6'd5;
			end else begin
				mem_valid = chance(70);
				wb_hold = chance(40);
				rollback = chance(5) ? mem_resp_pkg::thread_mask_t'(next_rand()) : '0;
			end
			step();
		end
		drain(wb_seen);
		end_test();

		// Held write port fills the queue and the excess is dropped.
		// Earlier tests may already have dropped responses, so only the increase counts
		start_test("overflow_hold");
		drop_base = drop_count;
		wb_hold = 1'b1;
		for (int i = 0; i < BURST_LEN; i++) begin
			mem_valid = 1'b1;
			mem_resp = rand_resp(mem_resp_pkg::NTHREADS, mem_resp_pkg::NREGS);
			step();
		end
		mem_valid = 1'b0;
		repeat (2) step();
		drain(wb_seen);
		if (wb_seen != BURST_KEPT) begin
			report_mismatch("writebacks after release", BURST_KEPT, wb_seen);
		end
		if (int'(drop_count) - int'(drop_base) != BURST_LEN - BURST_KEPT) begin
			report_mismatch("drop_count increase", BURST_LEN - BURST_KEPT,
				int'(drop_count) - int'(drop_base));
		end
		end_test();

		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Run limit covers every test plus its drain
	int cycles = 0;
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
verilog/mem_resp_pkg.sv
verilog/resp_capture.sv
verilog/mem_resp_fifo.sv
verilog/resp_writeback.sv
verilog/mem_resp_top.sv
dv/mem_resp_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the memory response path testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module mem_resp_tb \
	--Mdir "$BUILD_DIR" \
	-o mem_resp_sim

"./$BUILD_DIR/mem_resp_sim" > "$LOG" 2>&1 || true
cat "$LOG"

# The log decides the result
if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0
